/* bench/tb_cam_bist.sv */
//--------------------
// Testbench for the CAM with BIST
// Runs functional writes and compares against a reference CAM model,
// then two BIST marches with functional writes blocked while busy
//--------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cam_bist;

   import cam_bist_pkg::*;

   localparam int bist_timeout   = 200;
   localparam int result_timeout = 4;

   logic                  bist_clk;
   logic                  rst_b;
   cam_wr_t               func_wr;
   cam_cmp_t              func_cmp;
   logic                  bist_start;
   logic [cam_dwidth-1:0] bist_background;
   cam_match_t            match;
   logic                  match_valid;
   logic                  bist_busy;
   logic                  bist_done;
   logic                  bist_fail;

   // Reference CAM contents
   logic [cam_dwidth-1:0] ref_mem [cam_entries];
   logic                  ref_vld [cam_entries];
   // Outstanding functional compares, oldest first
   cam_match_t            exp_q [$];
   string                 name_q [$];
   // Edge count at which each result is due
   int unsigned           due_q [$];
   int unsigned           cyc;
   integer                seed;

   cam_bist_top i_cam_bist_top (
      .bist_clk        (bist_clk),
      .rst_b           (rst_b),
      .func_wr         (func_wr),
      .func_cmp        (func_cmp),
      .bist_start      (bist_start),
      .bist_background (bist_background),
      .match           (match),
      .match_valid     (match_valid),
      .bist_busy       (bist_busy),
      .bist_done       (bist_done),
      .bist_fail       (bist_fail)
   );

   // 4 ns period
   always #2 bist_clk = ~bist_clk;

   // Rising edges seen so far
   always @(posedge bist_clk) begin
      cyc <= cyc + 1;
   end

   //--------------------
   // Reference model and checks
   //--------------------

   // Valid entries equal to the key hit
   function automatic cam_match_t ref_match(input logic [cam_dwidth-1:0] key);
      cam_match_t m;
      m = '0;
      for (int e = 0; e < cam_entries; e++) begin
         if (ref_vld[e] && ref_mem[e] == key) begin
            m[e] = 1'b1;
         end
      end
      return m;
   endfunction

   task automatic stop_with_fail;
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check_match(input string name, input cam_match_t exp, input cam_match_t act);
      if (act !== exp) begin
         $display("ERROR %s: expected %b actual %b", name, exp, act);
         stop_with_fail();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR %s: expected %b actual %b", name, exp, act);
         stop_with_fail();
      end
   endtask

   // Results are graded mid-cycle, where match is stable
   // Each one must arrive exactly one cycle after its compare
   always @(negedge bist_clk) begin
      if (rst_b && exp_q.size() != 0 && due_q[0] == cyc) begin
         check_flag({name_q[0], " match_valid"}, 1'b1, match_valid);
         void'(due_q.pop_front());
         check_match(name_q.pop_front(), exp_q.pop_front(), match);
      end else if (rst_b && match_valid && exp_q.size() != 0) begin
         $display("match_valid came before its compare was due for %s", name_q[0]);
         stop_with_fail();
      end
   end

   //--------------------
   // Stimulus tasks
   //--------------------
   task automatic drive_write(input logic [cam_awidth-1:0] addr,
                              input logic [cam_dwidth-1:0] data);
      @(posedge bist_clk);
      #1;
      func_cmp.valid = 1'b0;
      func_wr.valid  = 1'b1;
      func_wr.addr   = addr;
      func_wr.data   = data;
      ref_mem[addr]  = data;
      ref_vld[addr]  = 1'b1;
   endtask

   // Expected vector taken from the model at issue time
   task automatic drive_compare(input logic [cam_dwidth-1:0] key, input string name);
      @(posedge bist_clk);
      #1;
      func_wr.valid  = 1'b0;
      func_cmp.valid = 1'b1;
      func_cmp.key   = key;
      exp_q.push_back(ref_match(key));
      name_q.push_back(name);
      due_q.push_back(cyc + 1);
   endtask

   task automatic wait_results(input string name);
      int n;
      @(posedge bist_clk);
      #1;
      func_wr.valid  = 1'b0;
      func_cmp.valid = 1'b0;
      n = 0;
      while (exp_q.size() != 0 && n < result_timeout) begin
         @(posedge bist_clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("TIMEOUT: match_valid never came for %s", name);
         stop_with_fail();
      end
   endtask

   task automatic run_bist(input logic [cam_dwidth-1:0] bg, input string name);
      int n;
      @(posedge bist_clk);
      #1;
      bist_start      = 1'b1;
      bist_background = bg;
      @(posedge bist_clk);
      #1;
      bist_start      = 1'b0;
      bist_background = ~bg;
      check_flag({name, " busy"}, 1'b1, bist_busy);
      n = 0;
      // Writes of the true background while busy must be dropped
      while (!bist_done && n < bist_timeout) begin
         func_wr.valid = bist_busy;
         func_wr.addr  = n[cam_awidth-1:0];
         func_wr.data  = bg;
         @(posedge bist_clk);
         #1;
         n++;
      end
      func_wr.valid = 1'b0;
      if (!bist_done) begin
         $display("TIMEOUT: bist_done never came for %s", name);
         stop_with_fail();
      end
      check_flag({name, " fail"}, 1'b0, bist_fail);
      check_flag({name, " busy end"}, 1'b0, bist_busy);
      @(posedge bist_clk);
      #1;
      check_flag({name, " done pulse"}, 1'b0, bist_done);
      check_flag({name, " fail hold"}, 1'b0, bist_fail);
      // Last pass leaves the inverted background everywhere
      for (int e = 0; e < cam_entries; e++) begin
         ref_mem[e] = ~bg;
         ref_vld[e] = 1'b1;
      end
      drive_compare(~bg, {name, " inverted bg"});
      drive_compare(bg, {name, " true bg"});
      drive_compare(bg ^ 16'h0100, {name, " one bit off"});
      wait_results(name);
   endtask

   //--------------------
   // Test sequence
   //--------------------
   initial begin
      logic [31:0]           rnd;
      logic [cam_dwidth-1:0] pool [4];
      seed            = 32'h7230;
      cyc             = 0;
      bist_clk        = 1'b0;
      rst_b           = 1'b0;
      func_wr         = '0;
      func_cmp        = '0;
      bist_start      = 1'b0;
      bist_background = '0;
      for (int e = 0; e < cam_entries; e++) begin
         ref_mem[e] = '0;
         ref_vld[e] = 1'b0;
      end
      repeat (10) @(posedge bist_clk);
      #1;
      rst_b = 1'b1;

      // Outputs come out of reset idle
      check_flag("reset busy", 1'b0, bist_busy);
      check_flag("reset done", 1'b0, bist_done);
      check_flag("reset fail", 1'b0, bist_fail);
      check_flag("reset match_valid", 1'b0, match_valid);

      // Empty array never hits
      drive_compare('0, "reset zero key");
      for (int i = 0; i < 4; i++) begin
         rnd = $random(seed);
         drive_compare(rnd[cam_dwidth-1:0], "reset random key");
      end
      wait_results("reset compares");

      // Small data pool forces duplicate entries
      for (int i = 0; i < 4; i++) begin
         rnd = $random(seed);
         pool[i] = rnd[cam_dwidth-1:0];
      end
      for (int i = 0; i < 12; i++) begin
         rnd = $random(seed);
         drive_write(rnd[cam_awidth-1:0], pool[rnd[9:8]]);
      end
      for (int e = 0; e < cam_entries; e++) begin
         drive_compare(ref_mem[e], "stored key");
      end
      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         drive_compare(rnd[cam_dwidth-1:0], "random key");
      end
      wait_results("functional compares");

      rnd = $random(seed);
      run_bist(rnd[cam_dwidth-1:0], "first bist");

      // New contents, then the march must restart cleanly
      for (int i = 0; i < 6; i++) begin
         rnd = $random(seed);
         drive_write(rnd[cam_awidth-1:0], pool[rnd[5:4]]);
      end
      for (int i = 0; i < 4; i++) begin
         drive_compare(pool[i], "rewritten key");
      end
      wait_results("rewritten compares");
      rnd = $random(seed);
      run_bist(rnd[cam_dwidth-1:0], "second bist");

      $display("NO ERRORS");
      $finish;
   end

endmodule : tb_cam_bist

`default_nettype wire

/* hw/cam_array.sv */
//--------------------
// Behavioral CAM storage
// One write port and one compare port, match registered one cycle
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cam_array (
   input  logic                        bist_clk,
   input  logic                        rst_b,
   input  cam_bist_pkg::cam_wr_t       wr,
   input  cam_bist_pkg::cam_cmp_t      cmp,
   output cam_bist_pkg::cam_match_t    match,
   output logic                        match_valid
);

   import cam_bist_pkg::*;

   logic [cam_dwidth-1:0]  mem_q [cam_entries];
   logic [cam_entries-1:0] vld_q;
   cam_match_t             hit;

   //--------------------
   // Write port
   //--------------------

   // Entry valid bits
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         vld_q <= '0;
      end else if (wr.valid) begin
         vld_q[wr.addr] <= 1'b1;
      end
   end

   // Entry data
   always_ff @(posedge bist_clk) begin
      if (wr.valid) begin
         mem_q[wr.addr] <= wr.data;
      end
   end

   //--------------------
   // Compare port
   //--------------------

   // Sees contents before a same-cycle write
   always_comb begin
      for (int e = 0; e < cam_entries; e++) begin
         hit[e] = vld_q[e] && (mem_q[e] == cmp.key);
      end
   end

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         match_valid <= 1'b0;
      end else begin
         match_valid <= cmp.valid;
      end
   end

   // Result held until the next compare
   always_ff @(posedge bist_clk) begin
      if (cmp.valid) begin
         match <= hit;
      end
   end

endmodule : cam_array

`default_nettype wire

/* hw/cam_bist_inhandler.sv */
//--------------------
// CAM input handler
// Inverts BIST data, builds the walking-mask key and picks BIST or
// functional traffic for the array
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cam_bist_inhandler (
   input  logic                       bist_clk,
   input  logic                       rst_b,
   input  cam_bist_pkg::bist_ctl_t    ctl,
   input  cam_bist_pkg::cam_wr_t      bist_wr,
   input  cam_bist_pkg::cam_cmp_t     bist_cmp,
   input  cam_bist_pkg::cam_wr_t      func_wr,
   input  cam_bist_pkg::cam_cmp_t     func_cmp,
   output cam_bist_pkg::cam_wr_t      wr,
   output cam_bist_pkg::cam_cmp_t     cmp,
   output logic                       exp_all,
   output logic                       exp_last
);

   import cam_bist_pkg::*;

   logic [cam_dwidth-1:0] mask_q;
   logic [cam_dwidth-1:0] inv_word;
   logic [cam_dwidth-1:0] bist_wdata;
   logic [cam_dwidth-1:0] bist_key;
   logic                  bist_cmp_go;

   //--------------------
   // Walking one-hot mask
   //--------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask_q <= cam_dwidth'(1);
      end else if (ctl.rotate_mask && bist_cmp.valid) begin
         mask_q <= {mask_q[cam_dwidth-2:0], mask_q[cam_dwidth-1]};
      end
   end

   // Inverted pass flips every bit
   assign inv_word   = {cam_dwidth{ctl.data_inv}};
   assign bist_wdata = bist_wr.data ^ inv_word;
   // Masked key differs from the stored word in one bit
   assign bist_key   = bist_cmp.key ^ inv_word ^ (ctl.mask_en ? mask_q : '0);

   // BIST owns the array while cm_mode is high
   always_comb begin
      if (ctl.cm_mode) begin
         wr.valid  = bist_wr.valid;
         wr.addr   = bist_wr.addr;
         wr.data   = bist_wdata;
         cmp.valid = bist_cmp.valid;
         cmp.key   = bist_key;
      end else begin
         wr  = func_wr;
         cmp = func_cmp;
      end
   end

   // Expected class, lined up with the array compare latency
   assign bist_cmp_go = ctl.cm_mode && bist_cmp.valid;

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         exp_all  <= 1'b0;
         exp_last <= 1'b0;
      end else begin
         exp_all  <= bist_cmp_go && ctl.expect_all;
         exp_last <= bist_cmp_go && ctl.last;
      end
   end

endmodule : cam_bist_inhandler

`default_nettype wire

/* hw/cam_bist_pkg.sv */
//--------------------
// Shared sizes and bus types for the CAM and its BIST logic
// Import into a module body, or use scoped names in port lists
//--------------------
`default_nettype none

package cam_bist_pkg;

   //--------------------
   // Array geometry
   //--------------------

   // Bits per CAM entry
   localparam int cam_dwidth  = 16;
   // Entry count and address width
   localparam int cam_entries = 8;
   localparam int cam_awidth  = 3;

   //--------------------
   // Traffic types
   //--------------------

   // One write into the array
   typedef struct packed {
      logic                  valid;
      logic [cam_awidth-1:0] addr;
      logic [cam_dwidth-1:0] data;
   } cam_wr_t;

   // One search of the array
   typedef struct packed {
      logic                  valid;
      logic [cam_dwidth-1:0] key;
   } cam_cmp_t;

   // Per-cycle control from the march sequencer
   typedef struct packed {
      logic cm_mode;      // BIST owns the array
      logic rotate_mask;  // Rotate the walking mask after this compare
      logic mask_en;      // Apply the mask to the key
      logic data_inv;     // Inverted background pass
      logic expect_all;   // Every entry should hit
      logic last;         // Final compare of the march
   } bist_ctl_t;

   // One hit bit per entry
   typedef logic [cam_entries-1:0] cam_match_t;

endpackage : cam_bist_pkg

`default_nettype wire

/* hw/cam_bist_seq.sv */
//--------------------
// March sequencer for the CAM BIST
// Writes a background, walks a masked compare over every bit, then
// compares unmasked, first with true data and then with inverted data
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cam_bist_seq (
   input  logic                                  bist_clk,
   input  logic                                  rst_b,
   input  logic                                  bist_start,
   input  logic [cam_bist_pkg::cam_dwidth-1:0]   bist_background,
   output cam_bist_pkg::bist_ctl_t               ctl,
   output cam_bist_pkg::cam_wr_t                 bist_wr,
   output cam_bist_pkg::cam_cmp_t                bist_cmp,
   output logic                                  bist_busy
);

   import cam_bist_pkg::*;

   // Phase encoding
   localparam logic [1:0] ph_idle = 2'd0;
   localparam logic [1:0] ph_wr   = 2'd1;
   localparam logic [1:0] ph_mcmp = 2'd2;
   localparam logic [1:0] ph_ucmp = 2'd3;

   // Counter covers both the entry walk and the bit walk
   localparam int cnt_w = $clog2(cam_dwidth);

   logic [1:0]            phase_q;
   logic [cnt_w-1:0]      cnt_q;
   logic                  pass_q;
   logic [cam_dwidth-1:0] bg_q;

   //--------------------
   // Phase and counter FSM
   //--------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         phase_q <= ph_idle;
         cnt_q   <= '0;
         pass_q  <= 1'b0;
      end else begin
         case (phase_q)
            ph_idle: begin
               // Start always at true background
               if (bist_start) begin
                  phase_q <= ph_wr;
                  cnt_q   <= '0;
                  pass_q  <= 1'b0;
               end
            end
            ph_wr: begin
               if (cnt_q == cnt_w'(cam_entries - 1)) begin
                  phase_q <= ph_mcmp;
                  cnt_q   <= '0;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            ph_mcmp: begin
               // One compare per data bit, mask ends back at bit 0
               if (cnt_q == cnt_w'(cam_dwidth - 1)) begin
                  phase_q <= ph_ucmp;
                  cnt_q   <= '0;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            default: begin
               // Unmasked compare closes the pass
               if (pass_q) begin
                  phase_q <= ph_idle;
               end else begin
                  phase_q <= ph_wr;
                  pass_q  <= 1'b1;
               end
            end
         endcase
      end
   end

   // Background captured on an accepted start
   always_ff @(posedge bist_clk) begin
      if (bist_start && phase_q == ph_idle) begin
         bg_q <= bist_background;
      end
   end

   //--------------------
   // Decoded outputs
   //--------------------
   assign bist_busy = (phase_q != ph_idle);

   always_comb begin
      ctl.cm_mode     = bist_busy;
      ctl.rotate_mask = (phase_q == ph_mcmp);
      ctl.mask_en     = (phase_q == ph_mcmp);
      ctl.data_inv    = pass_q;
      ctl.expect_all  = (phase_q == ph_ucmp);
      ctl.last        = (phase_q == ph_ucmp) && pass_q;
      // Raw data stays uninverted, handler applies data_inv
      bist_wr.valid   = (phase_q == ph_wr);
      bist_wr.addr    = cnt_q[cam_awidth-1:0];
      bist_wr.data    = bg_q;
      bist_cmp.valid  = (phase_q == ph_mcmp) || (phase_q == ph_ucmp);
      bist_cmp.key    = bg_q;
   end

endmodule : cam_bist_seq

`default_nettype wire

/* hw/cam_bist_top.sv */
//--------------------
// CAM with built-in self test
// Functional traffic goes straight through when BIST is idle
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cam_bist_top (
   input  logic                                  bist_clk,
   input  logic                                  rst_b,
   input  cam_bist_pkg::cam_wr_t                 func_wr,
   input  cam_bist_pkg::cam_cmp_t                func_cmp,
   input  logic                                  bist_start,
   input  logic [cam_bist_pkg::cam_dwidth-1:0]   bist_background,
   output cam_bist_pkg::cam_match_t              match,
   output logic                                  match_valid,
   output logic                                  bist_busy,
   output logic                                  bist_done,
   output logic                                  bist_fail
);

   import cam_bist_pkg::*;

   // Sequencer to handler
   bist_ctl_t ctl;
   cam_wr_t   bist_wr;
   cam_cmp_t  bist_cmp;
   // Handler to array and checker
   cam_wr_t   wr;
   cam_cmp_t  cmp;
   logic      exp_all;
   logic      exp_last;

   cam_bist_seq i_cam_bist_seq (
      .bist_clk        (bist_clk),
      .rst_b           (rst_b),
      .bist_start      (bist_start),
      .bist_background (bist_background),
      .ctl             (ctl),
      .bist_wr         (bist_wr),
      .bist_cmp        (bist_cmp),
      .bist_busy       (bist_busy)
   );

   cam_bist_inhandler i_cam_bist_inhandler (
      .bist_clk (bist_clk),
      .rst_b    (rst_b),
      .ctl      (ctl),
      .bist_wr  (bist_wr),
      .bist_cmp (bist_cmp),
      .func_wr  (func_wr),
      .func_cmp (func_cmp),
      .wr       (wr),
      .cmp      (cmp),
      .exp_all  (exp_all),
      .exp_last (exp_last)
   );

   cam_array i_cam_array (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .wr          (wr),
      .cmp         (cmp),
      .match       (match),
      .match_valid (match_valid)
   );

   cam_match_checker i_cam_match_checker (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .match       (match),
      .match_valid (match_valid),
      .exp_all     (exp_all),
      .exp_last    (exp_last),
      .bist_start  (bist_start),
      .bist_done   (bist_done),
      .bist_fail   (bist_fail)
   );

endmodule : cam_bist_top

`default_nettype wire

/* hw/cam_match_checker.sv */
//--------------------
// BIST result checker
// Grades each BIST match vector against all ones or all zeros,
// keeps a sticky fail and flags the end of the march
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cam_match_checker (
   input  logic                         bist_clk,
   input  logic                         rst_b,
   input  cam_bist_pkg::cam_match_t     match,
   input  logic                         match_valid,
   input  logic                         exp_all,
   input  logic                         exp_last,
   input  logic                         bist_start,
   output logic                         bist_done,
   output logic                         bist_fail
);

   import cam_bist_pkg::*;

   logic       start_q;
   logic       armed_q;
   cam_match_t expected;

   // Expected class for the result now on match
   assign expected = exp_all ? '1 : '0;

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         start_q   <= 1'b0;
         armed_q   <= 1'b0;
         bist_done <= 1'b0;
         bist_fail <= 1'b0;
      end else begin
         start_q   <= bist_start;
         bist_done <= 1'b0;
         // A functional compare taken with bist_start lands one cycle later
         // so grading starts a cycle after the start strobe
         if (start_q) begin
            armed_q <= 1'b1;
         end
         if (bist_start) begin
            bist_fail <= 1'b0;
         end
         if (armed_q && match_valid) begin
            if (match != expected) begin
               bist_fail <= 1'b1;
            end
            // Last result closes the run
            if (exp_last) begin
               armed_q   <= 1'b0;
               bist_done <= 1'b1;
            end
         end
      end
   end

endmodule : cam_match_checker

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the CAM BIST testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module tb_cam_bist -o sim_cam_bist
./obj_dir/sim_cam_bist | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

/* sources.f */
hw/cam_bist_pkg.sv
hw/cam_bist_seq.sv
hw/cam_bist_inhandler.sv
hw/cam_array.sv
hw/cam_match_checker.sv
hw/cam_bist_top.sv
bench/tb_cam_bist.sv
